// ==== design/l1d_pkg.sv ====
`default_nettype none

package l1d_pkg;

    localparam int ADDR_W          = 32;
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
    localparam int NUM_WAYS        = 2;
    localparam int NUM_SETS        = 16;
    localparam int OFFSET_W        = $clog2(BLOCK_W / 8);
    localparam int SET_W           = $clog2(NUM_SETS);
    localparam int TAG_W           = ADDR_W - SET_W - OFFSET_W;
    localparam int WAY_IDX_W       = $clog2(NUM_WAYS);
    localparam int WORD_SEL_W      = $clog2(WORDS_PER_BLOCK);

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BLOCK_W-1:0]    block_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SET_W-1:0]      set_idx_t;
    typedef logic [WAY_IDX_W-1:0]  way_idx_t;
    typedef logic [NUM_WAYS-1:0]   way_mask_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    typedef struct packed {
        addr_t addr;
        logic  we;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        addr_t  addr;
        logic   we;
        block_t data;
    } bus_req_t;

    typedef struct packed {
        tag_t   tag;
        block_t block;
    } way_entry_t;

    // One set, all ways side by side
    typedef way_entry_t [NUM_WAYS-1:0] row_t;

    typedef enum logic [2:0] {
        IDLE,
        ROW_OPEN,
        ARRAY_READ,
        ARRAY_WAIT,
        LOOKUP,
        BUS_READ_REQ,
        BUS_READ_WAIT,
        BUS_WRITE_REQ
    } ctrl_state_e;

    function automatic tag_t addr_tag(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic set_idx_t addr_set(addr_t a);
        return a[OFFSET_W +: SET_W];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[OFFSET_W-1 -: WORD_SEL_W];
    endfunction

    function automatic addr_t block_addr(tag_t t, set_idx_t s);
        return {t, s, {OFFSET_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== design/l1d_set_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_set_array import l1d_pkg::*; (
    input  logic      clk_i,
    input  set_idx_t  set_i,
    input  way_mask_t we_i,
    input  row_t      wrow_i,
    input  logic      rd_i,
    output row_t      rrow_o
);

    row_t mem [NUM_SETS];

    // Per-way write, whole set read back one cycle later
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (we_i[w]) begin
                mem[set_i][w] <= wrow_i[w];
            end
        end
        if (rd_i) begin
            rrow_o <= mem[set_i];
        end
    end

endmodule

`default_nettype wire

// ==== design/l1d_way_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_way_state import l1d_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  set_idx_t set_i,
    input  logic     mark_fill_i,
    input  logic     mark_dirty_i,
    input  logic     advance_i,
    input  way_idx_t way_i,

    output way_idx_t victim_way_o,
    output logic     victim_dirty_o,
    output logic     any_valid_o
);

    way_mask_t valid_q [NUM_SETS];
    way_mask_t dirty_q [NUM_SETS];
    way_idx_t  rr_q;

    // Lowest invalid way wins, round-robin otherwise
    always_comb begin
        victim_way_o = rr_q;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[set_i][w]) begin
                victim_way_o = way_idx_t'(w);
            end
        end
    end

    assign victim_dirty_o = dirty_q[set_i][victim_way_o];
    assign any_valid_o    = |valid_q[set_i];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (mark_fill_i) begin
                valid_q[set_i][way_i] <= 1'b1;
                dirty_q[set_i][way_i] <= 1'b0;
            end else if (mark_dirty_i) begin
                dirty_q[set_i][way_i] <= 1'b1;
            end
            if (advance_i) begin
                rr_q <= (rr_q == way_idx_t'(NUM_WAYS - 1)) ? '0 : rr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/l1d_row_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_row_buffer import l1d_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,

    input  logic      load_i,
    input  row_t      arr_row_i,
    input  logic      fill_i,
    input  way_idx_t  fill_way_i,
    input  tag_t      fill_tag_i,
    input  block_t    fill_block_i,
    input  logic      wr_word_i,
    input  addr_t     addr_i,
    input  word_t     wdata_i,
    input  logic      flush_done_i,
    input  way_idx_t  victim_way_i,

    output logic      hit_o,
    output way_idx_t  hit_way_o,
    output word_t     rd_word_o,
    output way_mask_t updated_o,
    output row_t      row_o,
    output tag_t      victim_tag_o,
    output block_t    victim_block_o
);

    row_t      row_q;
    set_idx_t  open_set_q;
    way_mask_t updated_q;
    way_mask_t valid_mirror_q [NUM_SETS];

    way_mask_t open_valid;
    set_idx_t  req_set;
    tag_t      req_tag;
    word_sel_t req_word;

    assign req_set    = addr_set(addr_i);
    assign req_tag    = addr_tag(addr_i);
    assign req_word   = addr_word(addr_i);
    assign open_valid = valid_mirror_q[open_set_q];

    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (open_valid[w] && open_set_q == req_set && row_q[w].tag == req_tag) begin
                hit_o     = 1'b1;
                hit_way_o = way_idx_t'(w);
            end
        end
    end

    assign rd_word_o      = row_q[hit_way_o].block[req_word*WORD_W +: WORD_W];
    assign updated_o      = updated_q;
    assign row_o          = row_q;
    assign victim_tag_o   = row_q[victim_way_i].tag;
    assign victim_block_o = row_q[victim_way_i].block;

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            row_q <= arr_row_i;
        end else if (fill_i) begin
            row_q[fill_way_i] <= '{tag: fill_tag_i, block: fill_block_i};
        end else if (wr_word_i) begin
            row_q[hit_way_o].block[req_word*WORD_W +: WORD_W] <= wdata_i;
        end
    end

    // Open set, modified ways and the valid copy for hit qualification
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            open_set_q <= '0;
            updated_q  <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mirror_q[s] <= '0;
            end
        end else if (flush_done_i) begin
            updated_q <= '0;
        end else if (load_i) begin
            open_set_q <= req_set;
            updated_q  <= '0;
        end else if (fill_i) begin
            open_set_q                         <= req_set;
            updated_q[fill_way_i]              <= 1'b1;
            valid_mirror_q[req_set][fill_way_i] <= 1'b1;
        end else if (wr_word_i) begin
            updated_q[hit_way_o] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/l1d_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_controller import l1d_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,

    input  logic      core_req_valid_i,
    input  core_req_t core_req_i,
    output logic      core_req_ready_o,
    output logic      core_rsp_valid_o,
    output word_t     core_rsp_data_o,

    output logic      bus_req_valid_o,
    output bus_req_t  bus_req_o,
    input  logic      bus_req_ready_i,
    input  logic      bus_rsp_valid_i,

    output set_idx_t  arr_set_o,
    output way_mask_t arr_we_o,
    output logic      arr_rd_o,

    output logic      rb_load_o,
    output logic      rb_fill_o,
    output way_idx_t  rb_fill_way_o,
    output logic      rb_wr_word_o,
    output logic      rb_flush_done_o,
    input  logic      rb_hit_i,
    input  way_idx_t  rb_hit_way_i,
    input  word_t     rb_rd_word_i,
    input  way_mask_t rb_updated_i,
    input  tag_t      rb_victim_tag_i,
    input  block_t    rb_victim_block_i,
    output addr_t     rb_addr_o,
    output word_t     rb_wdata_o,

    output set_idx_t  ws_set_o,
    output logic      ws_mark_fill_o,
    output logic      ws_mark_dirty_o,
    output logic      ws_advance_o,
    output way_idx_t  ws_way_o,
    input  way_idx_t  ws_victim_way_i,
    input  logic      ws_victim_dirty_i,
    input  logic      ws_any_valid_i
);

    ctrl_state_e state_q, state_d;
    core_req_t   req_q, req_d;
    set_idx_t    open_set_q, open_set_d;
    way_idx_t    fill_way_q, fill_way_d;
    bus_req_t    bus_q, bus_d;
    logic        bus_valid_q, bus_valid_d;
    logic        rsp_valid_q, rsp_valid_d;
    word_t       rsp_data_q, rsp_data_d;

    logic        accepting;
    logic        lookup;
    logic        alloc;
    logic        cur_we;
    set_idx_t    cur_set;

    // In IDLE and ROW_OPEN the lookup runs on the incoming request
    assign accepting        = (state_q == IDLE) || (state_q == ROW_OPEN);
    assign core_req_ready_o = accepting;
    assign rb_addr_o        = accepting ? core_req_i.addr  : req_q.addr;
    assign rb_wdata_o       = accepting ? core_req_i.wdata : req_q.wdata;
    assign cur_we           = accepting ? core_req_i.we    : req_q.we;
    assign cur_set          = addr_set(rb_addr_o);

    assign ws_set_o      = cur_set;
    assign ws_way_o      = (state_q == BUS_READ_WAIT) ? fill_way_q : rb_hit_way_i;
    assign arr_set_o     = open_set_q;
    assign rb_fill_way_o = fill_way_q;

    assign bus_req_valid_o  = bus_valid_q;
    assign bus_req_o        = bus_q;
    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_data_o  = rsp_data_q;

    always_comb begin
        state_d         = state_q;
        req_d           = req_q;
        open_set_d      = open_set_q;
        fill_way_d      = fill_way_q;
        bus_d           = bus_q;
        bus_valid_d     = bus_valid_q;
        rsp_valid_d     = 1'b0;
        rsp_data_d      = rsp_data_q;
        arr_we_o        = '0;
        arr_rd_o        = 1'b0;
        rb_load_o       = 1'b0;
        rb_fill_o       = 1'b0;
        rb_wr_word_o    = 1'b0;
        rb_flush_done_o = 1'b0;
        ws_mark_fill_o  = 1'b0;
        ws_mark_dirty_o = 1'b0;
        ws_advance_o    = 1'b0;
        lookup          = 1'b0;
        alloc           = 1'b0;

        case (state_q)
            IDLE, ROW_OPEN: begin
                if (core_req_valid_i) begin
                    req_d  = core_req_i;
                    lookup = 1'b1;
                end
            end
            ARRAY_READ: begin
                arr_rd_o = 1'b1;
                state_d  = ARRAY_WAIT;
            end
            ARRAY_WAIT: begin
                rb_load_o = 1'b1;
                state_d   = LOOKUP;
            end
            LOOKUP: lookup = 1'b1;
            BUS_READ_REQ: begin
                if (bus_req_ready_i) begin
                    bus_valid_d = 1'b0;
                    state_d     = BUS_READ_WAIT;
                end
            end
            BUS_READ_WAIT: begin
                if (bus_rsp_valid_i) begin
                    rb_fill_o      = 1'b1;
                    ws_mark_fill_o = 1'b1;
                    state_d        = LOOKUP;
                end
            end
            BUS_WRITE_REQ: begin
                // Write-back done, fetch the missing block next
                if (bus_req_ready_i) begin
                    bus_d   = '{addr: block_addr(addr_tag(req_q.addr), cur_set),
                                we: 1'b0, data: '0};
                    state_d = BUS_READ_REQ;
                end
            end
            default: state_d = IDLE;
        endcase

        if (lookup) begin
            if (rb_hit_i) begin
                if (cur_we) begin
                    rb_wr_word_o    = 1'b1;
                    ws_mark_dirty_o = 1'b1;
                end else begin
                    rsp_valid_d = 1'b1;
                    rsp_data_d  = rb_rd_word_i;
                end
                state_d = ROW_OPEN;
            end else if (cur_set != open_set_q) begin
                // Row switch: flush modified ways of the old set first
                arr_we_o        = rb_updated_i;
                rb_flush_done_o = 1'b1;
                open_set_d      = cur_set;
                if (ws_any_valid_i) begin
                    state_d = ARRAY_READ;
                end else begin
                    alloc = 1'b1;
                end
            end else begin
                alloc = 1'b1;
            end
        end

        if (alloc) begin
            fill_way_d   = ws_victim_way_i;
            ws_advance_o = 1'b1;
            bus_valid_d  = 1'b1;
            if (ws_victim_dirty_i) begin
                bus_d   = '{addr: block_addr(rb_victim_tag_i, cur_set),
                            we: 1'b1, data: rb_victim_block_i};
                state_d = BUS_WRITE_REQ;
            end else begin
                bus_d   = '{addr: block_addr(addr_tag(rb_addr_o), cur_set),
                            we: 1'b0, data: '0};
                state_d = BUS_READ_REQ;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= IDLE;
            open_set_q  <= '0;
            bus_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            open_set_q  <= open_set_d;
            bus_valid_q <= bus_valid_d;
            rsp_valid_q <= rsp_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        req_q      <= req_d;
        fill_way_q <= fill_way_d;
        bus_q      <= bus_d;
        rsp_data_q <= rsp_data_d;
    end

endmodule

`default_nettype wire

// ==== design/l1d_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_top import l1d_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,

    input  logic      core_req_valid_i,
    input  core_req_t core_req_i,
    output logic      core_req_ready_o,
    output logic      core_rsp_valid_o,
    output word_t     core_rsp_data_o,

    output logic      bus_req_valid_o,
    output bus_req_t  bus_req_o,
    input  logic      bus_req_ready_i,
    input  logic      bus_rsp_valid_i,
    input  block_t    bus_rsp_data_i
);

    set_idx_t  arr_set;
    way_mask_t arr_we;
    logic      arr_rd;
    row_t      arr_rrow;
    row_t      rb_row;

    logic      rb_load;
    logic      rb_fill;
    way_idx_t  rb_fill_way;
    logic      rb_wr_word;
    logic      rb_flush_done;
    logic      rb_hit;
    way_idx_t  rb_hit_way;
    word_t     rb_rd_word;
    way_mask_t rb_updated;
    tag_t      rb_victim_tag;
    block_t    rb_victim_block;
    addr_t     rb_addr;
    word_t     rb_wdata;

    set_idx_t  ws_set;
    logic      ws_mark_fill;
    logic      ws_mark_dirty;
    logic      ws_advance;
    way_idx_t  ws_way;
    way_idx_t  ws_victim_way;
    logic      ws_victim_dirty;
    logic      ws_any_valid;

    l1d_controller u_ctrl (
        .clk_i, .rstn_i,
        .core_req_valid_i, .core_req_i, .core_req_ready_o,
        .core_rsp_valid_o, .core_rsp_data_o,
        .bus_req_valid_o, .bus_req_o, .bus_req_ready_i,
        .bus_rsp_valid_i,
        .arr_set_o(arr_set), .arr_we_o(arr_we), .arr_rd_o(arr_rd),
        .rb_load_o(rb_load), .rb_fill_o(rb_fill), .rb_fill_way_o(rb_fill_way),
        .rb_wr_word_o(rb_wr_word), .rb_flush_done_o(rb_flush_done),
        .rb_hit_i(rb_hit), .rb_hit_way_i(rb_hit_way), .rb_rd_word_i(rb_rd_word),
        .rb_updated_i(rb_updated), .rb_victim_tag_i(rb_victim_tag),
        .rb_victim_block_i(rb_victim_block), .rb_addr_o(rb_addr), .rb_wdata_o(rb_wdata),
        .ws_set_o(ws_set), .ws_mark_fill_o(ws_mark_fill), .ws_mark_dirty_o(ws_mark_dirty),
        .ws_advance_o(ws_advance), .ws_way_o(ws_way), .ws_victim_way_i(ws_victim_way),
        .ws_victim_dirty_i(ws_victim_dirty), .ws_any_valid_i(ws_any_valid)
    );

    // Fill tag always belongs to the request being served
    l1d_row_buffer u_row_buf (
        .clk_i, .rstn_i,
        .load_i(rb_load), .arr_row_i(arr_rrow),
        .fill_i(rb_fill), .fill_way_i(rb_fill_way), .fill_tag_i(addr_tag(rb_addr)),
        .fill_block_i(bus_rsp_data_i),
        .wr_word_i(rb_wr_word), .addr_i(rb_addr), .wdata_i(rb_wdata),
        .flush_done_i(rb_flush_done), .victim_way_i(ws_victim_way),
        .hit_o(rb_hit), .hit_way_o(rb_hit_way), .rd_word_o(rb_rd_word),
        .updated_o(rb_updated), .row_o(rb_row),
        .victim_tag_o(rb_victim_tag), .victim_block_o(rb_victim_block)
    );

    l1d_way_state u_way_state (
        .clk_i, .rstn_i,
        .set_i(ws_set), .mark_fill_i(ws_mark_fill), .mark_dirty_i(ws_mark_dirty),
        .advance_i(ws_advance), .way_i(ws_way),
        .victim_way_o(ws_victim_way), .victim_dirty_o(ws_victim_dirty),
        .any_valid_o(ws_any_valid)
    );

    l1d_set_array u_set_array (
        .clk_i,
        .set_i(arr_set), .we_i(arr_we), .wrow_i(rb_row),
        .rd_i(arr_rd), .rrow_o(arr_rrow)
    );

endmodule

`default_nettype wire

// ==== verification/tb_l1d_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_top import l1d_pkg::*; ();

    localparam int    CLK_PERIOD     = 100;
    localparam int    DRIVE_DLY      = 1;
    localparam int    TIMEOUT_CYCLES = 100;
    localparam int    MAX_OPS        = 64;
    localparam string PATTERN_FILE   = "verification/l1d_patterns.txt";

    // Opcodes of the pattern file
    localparam logic [31:0] OP_READ      = 32'h0;
    localparam logic [31:0] OP_WRITE     = 32'h1;
    localparam logic [31:0] OP_READ_HIT  = 32'h2;
    localparam logic [31:0] OP_MEM_CHECK = 32'h3;
    localparam logic [31:0] OP_BUS_READS = 32'h4;
    localparam logic [31:0] OP_END       = 32'hf;

    logic      clk_i;
    logic      rstn_i;
    logic      core_req_valid_i;
    core_req_t core_req_i;
    logic      core_req_ready_o;
    logic      core_rsp_valid_o;
    word_t     core_rsp_data_o;
    logic      bus_req_valid_o;
    bus_req_t  bus_req_o;
    logic      bus_req_ready_i;
    logic      bus_rsp_valid_i;
    block_t    bus_rsp_data_i;

    logic [31:0] pattern_words [4*MAX_OPS];
    word_t       mem_words [addr_t];
    int          seed = 95628;
    int          bus_reads = 0;
    int          bus_writes = 0;

    l1d_top UUT (
        .clk_i, .rstn_i,
        .core_req_valid_i, .core_req_i, .core_req_ready_o,
        .core_rsp_valid_o, .core_rsp_data_o,
        .bus_req_valid_o, .bus_req_o, .bus_req_ready_i,
        .bus_rsp_valid_i, .bus_rsp_data_i
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic int random_delay();
        return {$random(seed)} % 4;
    endfunction

    // Untouched memory holds the inverted byte address
    function automatic word_t mem_read_word(addr_t addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return ~addr;
    endfunction

    function automatic block_t mem_read_block(addr_t base);
        block_t blk;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            blk[i*WORD_W +: WORD_W] = mem_read_word(base + addr_t'(4 * i));
        end
        return blk;
    endfunction

    task automatic mem_write_block(input addr_t base, input block_t blk);
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            mem_words[base + addr_t'(4 * i)] = blk[i*WORD_W +: WORD_W];
        end
    endtask

    // Called just after a rising edge and returns just after the accepting edge
    task automatic send_request(input addr_t addr, input logic we, input word_t wdata);
        int cycles;
        cycles = 0;
        core_req_valid_i = 1'b1;
        core_req_i       = '{addr: addr, we: we, wdata: wdata};
        @(negedge clk_i);
        while (!core_req_ready_o) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("Timeout: the DUT never accepted the core request");
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #DRIVE_DLY;
        core_req_valid_i = 1'b0;
        core_req_i       = '0;
    endtask

    task automatic wait_read_response(output word_t data, output int latency);
        latency = 1;
        @(negedge clk_i);
        while (!core_rsp_valid_o) begin
            if (latency >= TIMEOUT_CYCLES) begin
                report_failure("Timeout: no read response came back from the DUT");
            end
            latency++;
            @(negedge clk_i);
        end
        data = core_rsp_data_o;
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic wait_write_done();
        int cycles;
        cycles = 1;
        @(negedge clk_i);
        while (!core_req_ready_o) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure("Timeout: the DUT did not finish the write");
            end
            cycles++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    // Main memory model sampled at the falling edge and driven after the rising one
    initial begin : bus_model
        int       ready_cnt;
        int       rsp_cnt;
        logic     fire;
        addr_t    rsp_addr;
        bus_req_t req;
        ready_cnt       = -1;
        rsp_cnt         = -1;
        rsp_addr        = '0;
        bus_req_ready_i = 1'b0;
        bus_rsp_valid_i = 1'b0;
        bus_rsp_data_i  = '0;
        forever begin
            @(negedge clk_i);
            fire = rstn_i && bus_req_valid_o && bus_req_ready_i;
            if (fire) begin
                req = bus_req_o;
                check_value("bus address offset", 32'd0, 32'(req.addr[OFFSET_W-1:0]));
                if (req.we) begin
                    mem_write_block(req.addr, req.data);
                    bus_writes++;
                end else begin
                    bus_reads++;
                    rsp_addr = req.addr;
                    rsp_cnt  = random_delay();
                end
            end else if (rstn_i && bus_req_valid_o && ready_cnt < 0) begin
                ready_cnt = random_delay();
            end
            @(posedge clk_i);
            #DRIVE_DLY;
            bus_rsp_valid_i = 1'b0;
            if (rsp_cnt == 0) begin
                bus_rsp_valid_i = 1'b1;
                bus_rsp_data_i  = mem_read_block(rsp_addr);
                rsp_cnt         = -1;
            end else if (rsp_cnt > 0) begin
                rsp_cnt--;
            end
            if (fire) begin
                bus_req_ready_i = 1'b0;
            end else if (ready_cnt == 0) begin
                bus_req_ready_i = 1'b1;
                ready_cnt       = -1;
            end else if (ready_cnt > 0) begin
                ready_cnt--;
            end
        end
    end

    initial begin : main_sequence
        int          op_idx;
        int          latency;
        int          xfers_before;
        logic [31:0] opcode;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        word_t       rdata;
        string       name;
        rstn_i           = 1'b0;
        core_req_valid_i = 1'b0;
        core_req_i       = '0;
        for (int i = 0; i < 4 * MAX_OPS; i++) begin
            pattern_words[i] = OP_END;
        end
        $readmemh(PATTERN_FILE, pattern_words);

        repeat (2) @(posedge clk_i);
        #DRIVE_DLY;
        rstn_i = 1'b1;

        @(negedge clk_i);
        check_value("reset core_req_ready_o", 32'd1, 32'(core_req_ready_o));
        check_value("reset core_rsp_valid_o", 32'd0, 32'(core_rsp_valid_o));
        check_value("reset bus_req_valid_o", 32'd0, 32'(bus_req_valid_o));
        @(posedge clk_i);
        #DRIVE_DLY;

        for (op_idx = 0; op_idx < MAX_OPS; op_idx++) begin
            opcode   = pattern_words[4*op_idx];
            addr     = pattern_words[4*op_idx+1];
            wdata    = pattern_words[4*op_idx+2];
            expected = pattern_words[4*op_idx+3];
            if (opcode == OP_END) begin
                break;
            end
            name = $sformatf("op %0d addr %h", op_idx, addr);
            case (opcode)
                OP_READ: begin
                    send_request(addr, 1'b0, '0);
                    wait_read_response(rdata, latency);
                    check_value({name, " read data"}, expected, rdata);
                end
                OP_WRITE: begin
                    send_request(addr, 1'b1, wdata);
                    wait_write_done();
                end
                OP_READ_HIT: begin
                    xfers_before = bus_reads + bus_writes;
                    send_request(addr, 1'b0, '0);
                    wait_read_response(rdata, latency);
                    check_value({name, " read data"}, expected, rdata);
                    check_value({name, " hit latency"}, 32'd1, latency);
                    check_value({name, " bus transfers"}, xfers_before, bus_reads + bus_writes);
                    check_value({name, " bus_req_valid_o"}, 32'd0, 32'(bus_req_valid_o));
                end
                OP_MEM_CHECK: begin
                    check_value({name, " memory word"}, expected, mem_read_word(addr));
                end
                OP_BUS_READS: begin
                    check_value({name, " bus read count"}, expected, bus_reads);
                end
                default: begin
                    report_failure($sformatf("Unknown opcode %h in pattern entry %0d",
                                             opcode, op_idx));
                end
            endcase
        end

        if (op_idx == 0) begin
            report_failure("No operations were read from the pattern file");
        end else begin
            $display("Replayed %0d operations, %0d bus reads, %0d bus writes",
                     op_idx, bus_reads, bus_writes);
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/l1d_patterns.txt ====
// Columns: opcode address write_data expected (hex)
// Opcodes: 0 read, 1 write, 2 read that must hit, 3 memory word check, 4 bus read count, f end
0 00001000 00000000 ffffefff
2 00001008 00000000 ffffeff7
4 00000000 00000000 00000001
1 00001004 a5a50001 00000000
2 00001004 00000000 a5a50001
1 00002000 b6b60002 00000000
1 0000300c c7c70003 00000000
3 00001004 00000000 a5a50001
3 00001000 00000000 ffffefff
0 00001004 00000000 a5a50001
3 00002000 00000000 b6b60002
4 00000000 00000000 00000004
1 00001050 d8d80005 00000000
0 00001004 00000000 a5a50001
2 0000300c 00000000 c7c70003
0 00001050 00000000 d8d80005
4 00000000 00000000 00000005
2 00001058 00000000 ffffefa7
1 00002054 e9e90006 00000000
0 00003050 00000000 ffffcfaf
3 00001050 00000000 d8d80005
0 00004008 00000000 ffffbff7
0 00005000 00000000 ffffafff
3 0000300c 00000000 c7c70003
3 00003008 00000000 ffffcff7
0 00002054 00000000 e9e90006
4 00000000 00000000 00000009
3 00002054 00000000 ffffdfab
f 00000000 00000000 00000000

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_l1d_top
FILELIST    ?= tb.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing -j 0
LINT_FLAGS  ?= -Wall
PASS_STRING ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_STRING)" $(LOG) && echo "Simulation passed" \
		|| (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb.f ====
design/l1d_pkg.sv
design/l1d_set_array.sv
design/l1d_way_state.sv
design/l1d_row_buffer.sv
design/l1d_controller.sv
design/l1d_top.sv
verification/tb_l1d_top.sv
